/* hdl/soc_pkg.sv */
// ------------------------------------------------
// shared definitions for the peripheral subsystem
// address map, register offsets, widths and the
// debug gate delay, imported by every RTL block
// ------------------------------------------------

package soc_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  // target index, NONE marks an unmapped address
  typedef enum logic [1:0] {
    ROM   = 2'd0,
    CLINT = 2'd1,
    MBOX  = 2'd2,
    NONE  = 2'd3
  } periph_idx_e;

  // end address is excluded
  typedef struct packed {
    addr_t start_addr;
    addr_t end_addr;
  } addr_rule_t;

  // -----------------------------------------------
  // address map, indexed by periph_idx_e
  // -----------------------------------------------
  localparam addr_rule_t ADDR_MAP [3] = '{
    '{start_addr: 32'h0001_0000, end_addr: 32'h0001_1000},
    '{start_addr: 32'h0200_0000, end_addr: 32'h020C_0000},
    '{start_addr: 32'h1040_0000, end_addr: 32'h1040_1000}
  };

  // boot table: word i = {ROM_SIG, i}
  localparam int unsigned ROM_WORDS = 16;
  localparam int unsigned ROM_IDX_W = $clog2(ROM_WORDS);
  localparam logic [15:0] ROM_SIG   = 16'hB007;

  // -----------------------------------------------
  // register offsets inside each region
  // -----------------------------------------------
  localparam addr_t CLINT_MSIP_OFS        = 32'h0000_0000;
  localparam addr_t CLINT_MTIMECMP_LO_OFS = 32'h0000_4000;
  localparam addr_t CLINT_MTIMECMP_HI_OFS = 32'h0000_4004;
  localparam addr_t CLINT_MTIME_LO_OFS    = 32'h0000_BFF8;
  localparam addr_t CLINT_MTIME_HI_OFS    = 32'h0000_BFFC;

  localparam addr_t       MBOX_DOORBELL_OFS   = 32'h0000_0000;
  localparam addr_t       MBOX_COMPLETION_OFS = 32'h0000_0004;
  localparam addr_t       MBOX_PAYLOAD_OFS    = 32'h0000_0010;
  localparam int unsigned MBOX_PAYLOAD_WORDS  = 4;
  localparam int unsigned MBOX_IDX_W          = $clog2(MBOX_PAYLOAD_WORDS);

  // debug requests held off this many cycles after reset
  localparam int unsigned DEBUG_DELAY_CYCLES = 20;
  localparam int unsigned DEBUG_CNT_W        = $clog2(DEBUG_DELAY_CYCLES + 1);

endpackage

/* hdl/apb_if.sv */
// ------------------------------------------------
// APB bus bundle between decoder, targets and mux
// master drives the request, slave the response
// ------------------------------------------------

`timescale 1ns/1ns

interface apb_if;
  import soc_pkg::*;

  addr_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  data_t pwdata;
  data_t prdata;
  logic  pready;
  logic  pslverr;

  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );

endinterface

/* hdl/addr_decode.sv */
// ------------------------------------------------
// address decode stage, purely combinational
// matches paddr against ADDR_MAP, forwards the
// region offset and selects one target
// ------------------------------------------------

`timescale 1ns/1ns

module addr_decode (
  apb_if.slave               tgt_bus,
  apb_if.master              rom_bus,
  apb_if.master              clint_bus,
  apb_if.master              mbox_bus,
  output soc_pkg::periph_idx_e sel_o
);
  import soc_pkg::*;

  addr_t offset;

  function automatic logic in_rule(addr_t addr, addr_rule_t rule);
    return (addr >= rule.start_addr) && (addr < rule.end_addr);
  endfunction

  // first matching rule wins, the regions do not overlap anyway
  always_comb begin
    sel_o  = NONE;
    offset = '0;
    if (in_rule(tgt_bus.paddr, ADDR_MAP[ROM])) begin
      sel_o  = ROM;
      offset = tgt_bus.paddr - ADDR_MAP[ROM].start_addr;
    end else if (in_rule(tgt_bus.paddr, ADDR_MAP[CLINT])) begin
      sel_o  = CLINT;
      offset = tgt_bus.paddr - ADDR_MAP[CLINT].start_addr;
    end else if (in_rule(tgt_bus.paddr, ADDR_MAP[MBOX])) begin
      sel_o  = MBOX;
      offset = tgt_bus.paddr - ADDR_MAP[MBOX].start_addr;
    end
  end

  // psel only toward the hit, other request fields shared
  assign rom_bus.psel   = tgt_bus.psel && (sel_o == ROM);
  assign clint_bus.psel = tgt_bus.psel && (sel_o == CLINT);
  assign mbox_bus.psel  = tgt_bus.psel && (sel_o == MBOX);

  assign rom_bus.paddr   = offset;
  assign clint_bus.paddr = offset;
  assign mbox_bus.paddr  = offset;

  assign rom_bus.penable   = tgt_bus.penable;
  assign clint_bus.penable = tgt_bus.penable;
  assign mbox_bus.penable  = tgt_bus.penable;

  assign rom_bus.pwrite   = tgt_bus.pwrite;
  assign clint_bus.pwrite = tgt_bus.pwrite;
  assign mbox_bus.pwrite  = tgt_bus.pwrite;

  assign rom_bus.pwdata   = tgt_bus.pwdata;
  assign clint_bus.pwdata = tgt_bus.pwdata;
  assign mbox_bus.pwdata  = tgt_bus.pwdata;

endmodule

/* hdl/boot_rom.sv */
// ------------------------------------------------
// boot table behind APB, one wait state
// word captured on the first access cycle, pready
// raised on the second
// ------------------------------------------------

`timescale 1ns/1ns

module boot_rom (
  input  logic clk_i,
  input  logic ndmreset_n,
  apb_if.slave bus
);
  import soc_pkg::*;

  data_t rom_tbl [ROM_WORDS];
  data_t word_q;
  logic  err_q;
  logic  rd_valid_q;
  logic  access;
  logic  bad_req;

  for (genvar i = 0; i < ROM_WORDS; i++) begin : g_tbl
    assign rom_tbl[i] = {ROM_SIG, 16'(i)};
  end

  assign access  = bus.psel && bus.penable;
  // writes and anything past the table are refused
  assign bad_req = bus.pwrite || (bus.paddr >= addr_t'(ROM_WORDS * 4));

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rd_valid_q <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      rd_valid_q <= access && !rd_valid_q;
      if (access && !rd_valid_q) begin
        err_q <= bad_req;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && !rd_valid_q) begin
      word_q <= bad_req ? '0 : rom_tbl[bus.paddr[ROM_IDX_W+1:2]];
    end
  end

  assign bus.prdata  = word_q;
  assign bus.pready  = access && rd_valid_q;
  assign bus.pslverr = access && rd_valid_q && err_q;

endmodule

/* hdl/clint_timer.sv */
// ------------------------------------------------
// core-local interruptor: msip, mtimecmp, mtime
// mtime advances on every second rising edge of
// the synchronized rtc input
// ------------------------------------------------

`timescale 1ns/1ns

module clint_timer (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic rtc_i,
  apb_if.slave bus,
  output logic timer_irq_o,
  output logic ipi_o
);
  import soc_pkg::*;

  logic [1:0]              rtc_sync_q;
  logic                    rtc_last_q;
  logic                    rtc_half_q;
  logic                    rtc_rise;
  logic                    tick;
  logic [2*DATA_WIDTH-1:0] mtime_q;
  logic [2*DATA_WIDTH-1:0] mtimecmp_q;
  logic                    msip_q;
  logic                    access;
  logic                    wr_en;
  logic                    reg_hit;

  // ------------------------------------------------
  // rtc synchronizer and divide by two
  // ------------------------------------------------
  assign rtc_rise = rtc_sync_q[1] && !rtc_last_q;
  assign tick     = rtc_rise && rtc_half_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_last_q <= 1'b0;
      rtc_half_q <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_last_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_half_q <= !rtc_half_q;
      end
    end
  end

  // ------------------------------------------------
  // register file
  // ------------------------------------------------
  assign access = bus.psel && bus.penable;
  assign wr_en  = access && bus.pwrite && reg_hit;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      if (wr_en && bus.paddr == CLINT_MSIP_OFS) begin
        msip_q <= bus.pwdata[0];
      end
      if (wr_en && bus.paddr == CLINT_MTIMECMP_LO_OFS) begin
        mtimecmp_q[DATA_WIDTH-1:0] <= bus.pwdata;
      end
      if (wr_en && bus.paddr == CLINT_MTIMECMP_HI_OFS) begin
        mtimecmp_q[2*DATA_WIDTH-1:DATA_WIDTH] <= bus.pwdata;
      end
      // a software write to mtime beats the tick
      if (wr_en && bus.paddr == CLINT_MTIME_LO_OFS) begin
        mtime_q[DATA_WIDTH-1:0] <= bus.pwdata;
      end else if (wr_en && bus.paddr == CLINT_MTIME_HI_OFS) begin
        mtime_q[2*DATA_WIDTH-1:DATA_WIDTH] <= bus.pwdata;
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
    end
  end

  always_comb begin
    reg_hit    = 1'b1;
    bus.prdata = '0;
    case (bus.paddr)
      CLINT_MSIP_OFS:        bus.prdata = {{(DATA_WIDTH-1){1'b0}}, msip_q};
      CLINT_MTIMECMP_LO_OFS: bus.prdata = mtimecmp_q[DATA_WIDTH-1:0];
      CLINT_MTIMECMP_HI_OFS: bus.prdata = mtimecmp_q[2*DATA_WIDTH-1:DATA_WIDTH];
      CLINT_MTIME_LO_OFS:    bus.prdata = mtime_q[DATA_WIDTH-1:0];
      CLINT_MTIME_HI_OFS:    bus.prdata = mtime_q[2*DATA_WIDTH-1:DATA_WIDTH];
      default:               reg_hit    = 1'b0;
    endcase
  end

  assign bus.pready  = access;
  assign bus.pslverr = access && !reg_hit;

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

/* hdl/mbox_doorbell.sv */
// ------------------------------------------------
// mailbox: doorbell and completion flags plus
// four payload words, zero-wait APB access
// ------------------------------------------------

`timescale 1ns/1ns

module mbox_doorbell (
  input  logic clk_i,
  input  logic ndmreset_n,
  apb_if.slave bus,
  output logic doorbell_irq_o,
  output logic completion_irq_o
);
  import soc_pkg::*;

  data_t                 payload_q [MBOX_PAYLOAD_WORDS];
  logic                  doorbell_q;
  logic                  completion_q;
  logic                  access;
  logic                  pay_hit;
  logic                  reg_hit;
  addr_t                 pay_ofs;
  logic [MBOX_IDX_W-1:0] pay_idx;

  assign access  = bus.psel && bus.penable;
  assign pay_ofs = bus.paddr - MBOX_PAYLOAD_OFS;
  assign pay_idx = pay_ofs[MBOX_IDX_W+1:2];
  // word aligned and inside the payload window
  assign pay_hit = (bus.paddr >= MBOX_PAYLOAD_OFS)
                && (pay_ofs < addr_t'(MBOX_PAYLOAD_WORDS * 4))
                && (bus.paddr[1:0] == 2'b00);
  assign reg_hit = pay_hit || (bus.paddr == MBOX_DOORBELL_OFS)
                || (bus.paddr == MBOX_COMPLETION_OFS);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      doorbell_q   <= 1'b0;
      completion_q <= 1'b0;
    end else if (access && bus.pwrite) begin
      if (bus.paddr == MBOX_DOORBELL_OFS) begin
        doorbell_q <= bus.pwdata[0];
      end
      if (bus.paddr == MBOX_COMPLETION_OFS) begin
        completion_q <= bus.pwdata[0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && bus.pwrite && pay_hit) begin
      payload_q[pay_idx] <= bus.pwdata;
    end
  end

  always_comb begin
    bus.prdata = '0;
    if (pay_hit) begin
      bus.prdata = payload_q[pay_idx];
    end else if (bus.paddr == MBOX_DOORBELL_OFS) begin
      bus.prdata = {{(DATA_WIDTH-1){1'b0}}, doorbell_q};
    end else if (bus.paddr == MBOX_COMPLETION_OFS) begin
      bus.prdata = {{(DATA_WIDTH-1){1'b0}}, completion_q};
    end
  end

  assign bus.pready  = access;
  assign bus.pslverr = access && !reg_hit;

  assign doorbell_irq_o   = doorbell_q;
  assign completion_irq_o = completion_q;

endmodule

/* hdl/resp_mux.sv */
// ------------------------------------------------
// response stage, combinational
// returns the selected target's answer, errors an
// unmapped access in its first access cycle
// ------------------------------------------------

`timescale 1ns/1ns

module resp_mux (
  input  soc_pkg::periph_idx_e sel_i,
  apb_if.slave                 rom_bus,
  apb_if.slave                 clint_bus,
  apb_if.slave                 mbox_bus,
  output soc_pkg::data_t       prdata_o,
  output logic                 pready_o,
  output logic                 pslverr_o,
  input  logic                 psel_i,
  input  logic                 penable_i
);
  import soc_pkg::*;

  logic access;

  assign access = psel_i && penable_i;

  // only the response half of each bus is read here
  always_comb begin
    prdata_o  = '0;
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    if (access) begin
      case (sel_i)
        ROM: begin
          prdata_o  = rom_bus.prdata;
          pready_o  = rom_bus.pready;
          pslverr_o = rom_bus.pslverr;
        end
        CLINT: begin
          prdata_o  = clint_bus.prdata;
          pready_o  = clint_bus.pready;
          pslverr_o = clint_bus.pslverr;
        end
        MBOX: begin
          prdata_o  = mbox_bus.prdata;
          pready_o  = mbox_bus.pready;
          pslverr_o = mbox_bus.pslverr;
        end
        default: begin
          pready_o  = 1'b1;
          pslverr_o = 1'b1;
        end
      endcase
    end
  end

endmodule

/* hdl/periph_subsystem.sv */
// ------------------------------------------------
// peripheral subsystem top: one APB slave port in
// front of boot ROM, CLINT and mailbox, plus the
// gate that blocks debug requests after reset
// ------------------------------------------------

`timescale 1ns/1ns

module periph_subsystem (
  input  logic           clk_i,
  input  logic           ndmreset_n,
  input  logic           rtc_i,
  input  soc_pkg::addr_t paddr_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  soc_pkg::data_t pwdata_i,
  output soc_pkg::data_t prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  input  logic           debug_req_i,
  output logic           debug_req_o,
  output logic           timer_irq_o,
  output logic           ipi_o,
  output logic           doorbell_irq_o,
  output logic           completion_irq_o
);
  import soc_pkg::*;

  periph_idx_e            sel;
  logic [DEBUG_CNT_W-1:0] dbg_cnt_q;

  apb_if up_bus ();
  apb_if rom_bus ();
  apb_if clint_bus ();
  apb_if mbox_bus ();

  // ------------------------------------------------
  // bus tree
  // ------------------------------------------------
  assign up_bus.paddr   = paddr_i;
  assign up_bus.psel    = psel_i;
  assign up_bus.penable = penable_i;
  assign up_bus.pwrite  = pwrite_i;
  assign up_bus.pwdata  = pwdata_i;

  addr_decode i_addr_decode (
    .tgt_bus   ( up_bus    ),
    .rom_bus   ( rom_bus   ),
    .clint_bus ( clint_bus ),
    .mbox_bus  ( mbox_bus  ),
    .sel_o     ( sel       )
  );

  boot_rom i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .bus        ( rom_bus    )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus         ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  mbox_doorbell i_mbox_doorbell (
    .clk_i            ( clk_i            ),
    .ndmreset_n       ( ndmreset_n       ),
    .bus              ( mbox_bus         ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  // the mux closes the upstream bus by driving its response half
  resp_mux i_resp_mux (
    .sel_i     ( sel            ),
    .rom_bus   ( rom_bus        ),
    .clint_bus ( clint_bus      ),
    .mbox_bus  ( mbox_bus       ),
    .prdata_o  ( up_bus.prdata  ),
    .pready_o  ( up_bus.pready  ),
    .pslverr_o ( up_bus.pslverr ),
    .psel_i    ( psel_i         ),
    .penable_i ( penable_i      )
  );

  assign prdata_o  = up_bus.prdata;
  assign pready_o  = up_bus.pready;
  assign pslverr_o = up_bus.pslverr;

  // ------------------------------------------------
  // debug request gate
  // ------------------------------------------------
  // gives the core time to run boot code before a halt
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dbg_cnt_q <= DEBUG_CNT_W'(DEBUG_DELAY_CYCLES);
    end else if (dbg_cnt_q != '0) begin
      dbg_cnt_q <= dbg_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (dbg_cnt_q == '0) && debug_req_i;

endmodule

/* tb/tb_tasks.svh */
// ------------------------------------------------
// APB driver, compare tasks and directed tests
// included inside the testbench top module
// ------------------------------------------------

// ------------------------------------------------
// compare tasks
// ------------------------------------------------
task automatic compare_data(input string name, input data_t exp, input data_t act);
  if (act !== exp) begin
    err_count++;
    $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
  end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    err_count++;
    $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
  end
endtask

task automatic compare_err(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    err_count++;
    $display("Fail at %0t ns: %s pslverr expected %b, got %b", $time, name, exp, act);
  end
endtask

// ------------------------------------------------
// APB driver
// ------------------------------------------------
task automatic apb_transfer(input addr_t addr, input logic write, input data_t wdata,
                            output data_t rdata, output logic err);
  int unsigned waited;
  logic        done;
  rdata  = 'x;
  err    = 1'bx;
  done   = 1'b0;
  waited = 0;
  @(posedge clk_i);
  paddr_i   <= addr;
  pwrite_i  <= write;
  pwdata_i  <= wdata;
  psel_i    <= 1'b1;
  penable_i <= 1'b0;
  @(posedge clk_i);
  penable_i <= 1'b1;
  // response sampled mid cycle and the transfer closes on the next edge
  while (!done && waited < APB_TIMEOUT) begin
    @(negedge clk_i);
    if (pready_o) begin
      rdata = prdata_o;
      err   = pslverr_o;
      done  = 1'b1;
    end else begin
      waited++;
    end
    @(posedge clk_i);
  end
  psel_i    <= 1'b0;
  penable_i <= 1'b0;
  if (!done) begin
    timeout_count++;
    $display("Timeout at %0t ns: pready_o never rose for address 0x%08h", $time, addr);
  end
endtask

task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
  data_t unused_rdata;
  apb_transfer(addr, 1'b1, wdata, unused_rdata, err);
endtask

task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
  apb_transfer(addr, 1'b0, '0, rdata, err);
endtask

// ------------------------------------------------
// directed tests
// ------------------------------------------------
task automatic test_debug_gate();
  int unsigned i;
  for (i = 1; i < DEBUG_DELAY_CYCLES; i++) begin
    @(posedge clk_i);
    @(negedge clk_i);
    compare_bit($sformatf("debug_req_o cycle %0d", i), 1'b0, debug_req_o);
  end
  repeat (2) @(posedge clk_i);
  @(negedge clk_i);
  compare_bit("debug_req_o after delay", 1'b1, debug_req_o);
  @(posedge clk_i);
  debug_req_i <= 1'b0;
  @(negedge clk_i);
  compare_bit("debug_req_o released", 1'b0, debug_req_o);
endtask

task automatic test_rom();
  int unsigned i;
  data_t       rdata;
  logic        err;
  for (i = 0; i < ROM_WORDS; i++) begin
    apb_read(ADDR_MAP[ROM].start_addr + addr_t'(4 * i), rdata, err);
    compare_data($sformatf("rom word %0d", i), {ROM_SIG, 16'(i)}, rdata);
    compare_err($sformatf("rom word %0d", i), 1'b0, err);
  end
  apb_write(ADDR_MAP[ROM].start_addr, lfsr_word(), err);
  compare_err("rom write", 1'b1, err);
endtask

task automatic test_unmapped();
  addr_t       bad_addr [5];
  int unsigned i;
  data_t       rdata;
  logic        err;
  // just past each region end and both ends of the address space
  bad_addr = '{32'h0000_0000, ADDR_MAP[ROM].end_addr, ADDR_MAP[CLINT].end_addr,
               ADDR_MAP[MBOX].end_addr, 32'hFFFF_FFFC};
  for (i = 0; i < 5; i++) begin
    apb_read(bad_addr[i], rdata, err);
    compare_data($sformatf("unmapped read 0x%08h", bad_addr[i]), '0, rdata);
    compare_err($sformatf("unmapped read 0x%08h", bad_addr[i]), 1'b1, err);
    apb_write(bad_addr[i], lfsr_word(), err);
    compare_err($sformatf("unmapped write 0x%08h", bad_addr[i]), 1'b1, err);
  end
endtask

task automatic test_clint();
  addr_t base;
  data_t rdata;
  logic  err;
  base = ADDR_MAP[CLINT].start_addr;
  apb_write(base + CLINT_MSIP_OFS, 32'd1, err);
  compare_err("msip write", 1'b0, err);
  @(negedge clk_i);
  compare_bit("ipi_o", 1'b1, ipi_o);
  apb_write(base + CLINT_MSIP_OFS, 32'd0, err);
  @(negedge clk_i);
  compare_bit("ipi_o", 1'b0, ipi_o);

  // two rtc rising edges per mtime step
  rtc_pulses(2 * RTC_TICKS);
  apb_read(base + CLINT_MTIME_LO_OFS, rdata, err);
  compare_data("mtime lo", data_t'(RTC_TICKS), rdata);
  compare_err("mtime lo", 1'b0, err);
  apb_read(base + CLINT_MTIME_HI_OFS, rdata, err);
  compare_data("mtime hi", '0, rdata);

  apb_write(base + CLINT_MTIMECMP_HI_OFS, '0, err);
  apb_write(base + CLINT_MTIMECMP_LO_OFS, data_t'(RTC_TICKS + 2), err);
  compare_err("mtimecmp lo write", 1'b0, err);
  @(negedge clk_i);
  compare_bit("timer_irq_o before compare", 1'b0, timer_irq_o);
  rtc_pulses(4);
  @(negedge clk_i);
  compare_bit("timer_irq_o at compare", 1'b1, timer_irq_o);
endtask

task automatic test_mbox();
  addr_t       base;
  data_t       sent [MBOX_PAYLOAD_WORDS];
  data_t       rdata;
  logic        err;
  int unsigned i;
  base = ADDR_MAP[MBOX].start_addr;
  for (i = 0; i < MBOX_PAYLOAD_WORDS; i++) begin
    sent[i] = lfsr_word();
    apb_write(base + MBOX_PAYLOAD_OFS + addr_t'(4 * i), sent[i], err);
    compare_err($sformatf("payload %0d write", i), 1'b0, err);
  end
  for (i = 0; i < MBOX_PAYLOAD_WORDS; i++) begin
    apb_read(base + MBOX_PAYLOAD_OFS + addr_t'(4 * i), rdata, err);
    compare_data($sformatf("payload %0d", i), sent[i], rdata);
  end

  // one flag at a time so each output is seen on its own
  apb_write(base + MBOX_DOORBELL_OFS, 32'd1, err);
  @(negedge clk_i);
  compare_bit("doorbell_irq_o", 1'b1, doorbell_irq_o);
  compare_bit("completion_irq_o idle", 1'b0, completion_irq_o);
  apb_write(base + MBOX_COMPLETION_OFS, 32'd1, err);
  @(negedge clk_i);
  compare_bit("doorbell_irq_o held", 1'b1, doorbell_irq_o);
  compare_bit("completion_irq_o", 1'b1, completion_irq_o);
  apb_read(base + MBOX_DOORBELL_OFS, rdata, err);
  compare_data("doorbell register", 32'd1, rdata);

  apb_write(base + MBOX_DOORBELL_OFS, 32'd0, err);
  @(negedge clk_i);
  compare_bit("doorbell_irq_o cleared", 1'b0, doorbell_irq_o);
  compare_bit("completion_irq_o held", 1'b1, completion_irq_o);
  apb_read(base + MBOX_DOORBELL_OFS, rdata, err);
  compare_data("doorbell register cleared", 32'd0, rdata);
  apb_read(base + MBOX_COMPLETION_OFS, rdata, err);
  compare_data("completion register", 32'd1, rdata);

  apb_write(base + MBOX_COMPLETION_OFS, 32'd0, err);
  @(negedge clk_i);
  compare_bit("completion_irq_o cleared", 1'b0, completion_irq_o);
endtask

/* tb/tb_periph.sv */
// ------------------------------------------------
// testbench top for the peripheral subsystem
// clock, reset, rtc stimulus, LFSR and the test
// sequence, tasks come from the included header
// ------------------------------------------------

`timescale 1ns/1ns

module tb_periph;
  import soc_pkg::*;

  localparam int unsigned APB_TIMEOUT = 16;
  localparam int unsigned RTC_HALF    = 4;
  localparam int unsigned RTC_TICKS   = 3;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic  clk_i;
  logic  ndmreset_n;
  logic  rtc_i;
  addr_t paddr_i;
  logic  psel_i;
  logic  penable_i;
  logic  pwrite_i;
  data_t pwdata_i;
  data_t prdata_o;
  logic  pready_o;
  logic  pslverr_o;
  logic  debug_req_i;
  logic  debug_req_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  doorbell_irq_o;
  logic  completion_irq_o;

  int unsigned err_count;
  int unsigned timeout_count;
  logic [31:0] lfsr_state;

  periph_subsystem DUT (
    .clk_i            ( clk_i            ),
    .ndmreset_n       ( ndmreset_n       ),
    .rtc_i            ( rtc_i            ),
    .paddr_i          ( paddr_i          ),
    .psel_i           ( psel_i           ),
    .penable_i        ( penable_i        ),
    .pwrite_i         ( pwrite_i         ),
    .pwdata_i         ( pwdata_i         ),
    .prdata_o         ( prdata_o         ),
    .pready_o         ( pready_o         ),
    .pslverr_o        ( pslverr_o        ),
    .debug_req_i      ( debug_req_i      ),
    .debug_req_o      ( debug_req_o      ),
    .timer_irq_o      ( timer_irq_o      ),
    .ipi_o            ( ipi_o            ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------------------------
  // Galois LFSR, one step per bit taken
  // ------------------------------------------------
  function automatic logic lfsr_bit();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out_bit;
  endfunction

  function automatic data_t lfsr_word();
    data_t word;
    word = '0;
    repeat (DATA_WIDTH) begin
      word = {word[DATA_WIDTH-2:0], lfsr_bit()};
    end
    return word;
  endfunction

  // slow rtc pulses, each high and low for several clocks
  task automatic rtc_pulses(input int unsigned count);
    repeat (count) begin
      @(posedge clk_i);
      rtc_i <= 1'b1;
      repeat (RTC_HALF) @(posedge clk_i);
      rtc_i <= 1'b0;
      repeat (RTC_HALF) @(posedge clk_i);
    end
  endtask

  `include "tb_tasks.svh"

  initial begin
    clk_i         = 1'b0;
    ndmreset_n    = 1'b0;
    rtc_i         = 1'b0;
    paddr_i       = '0;
    psel_i        = 1'b0;
    penable_i     = 1'b0;
    pwrite_i      = 1'b0;
    pwdata_i      = '0;
    debug_req_i   = 1'b1;
    err_count     = 0;
    timeout_count = 0;
    lfsr_state    = 32'd30;

    repeat (10) @(posedge clk_i);
    ndmreset_n <= 1'b1;

    // the gate test counts cycles from reset release, so it goes first
    test_debug_gate();
    test_rom();
    test_unmapped();
    test_clint();
    test_mbox();

    $display("summary: %0d mismatches, %0d timeouts", err_count, timeout_count);
    if ((err_count + timeout_count) == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+tb
hdl/soc_pkg.sv
hdl/apb_if.sv
hdl/addr_decode.sv
hdl/boot_rom.sv
hdl/clint_timer.sv
hdl/mbox_doorbell.sv
hdl/resp_mux.sv
hdl/periph_subsystem.sv
tb/tb_periph.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_periph
FILELIST  = all.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@! grep -q "Test failed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
